// File: cache_geom_pkg.sv
// geometry of the 8-way set and its pseudo-LRU tree
// tree bits record the most recent direction, 1 = upper half or odd way

package cache_geom_pkg;

    localparam int num_ways  = 8;
    localparam int way_bits  = 3;
    localparam int plru_bits = 7;

    typedef logic [way_bits-1:0]  way_idx_t;
    typedef logic [num_ways-1:0]  way_vec_t;
    typedef logic [plru_bits-1:0] plru_t;

    // root picks the half, mids pick the pair
    localparam int plru_root   = 3;
    localparam int plru_lo_mid = 1;
    localparam int plru_hi_mid = 5;

    // leaves pick the way inside a pair
    localparam int plru_leaf_01 = 0;
    localparam int plru_leaf_23 = 2;
    localparam int plru_leaf_45 = 4;
    localparam int plru_leaf_67 = 6;

endpackage

// File: cache_ctrl_pkg.sv
// controller state and request encodings
// read and write are assumed never high together

package cache_ctrl_pkg;

    typedef enum logic [1:0] {
        st_idle       = 2'd0,
        st_tag_check  = 2'd1,
        st_miss_clean = 2'd2,
        st_miss_dirty = 2'd3
    } ctrl_state_t;

    // decoded from the cpu read and write lines
    typedef enum logic [1:0] {
        req_none  = 2'd0,
        req_read  = 2'd1,
        req_write = 2'd2
    } req_kind_t;

endpackage

// File: plru_tree.sv
// tree pseudo-LRU for 8 ways, purely combinational
// plru_next is only meaningful when hit_way is a real hit

`timescale 1ns/1ps

module plru_tree import cache_geom_pkg::*; (
    input  plru_t    plru,
    input  way_idx_t hit_way,
    output plru_t    plru_next,
    output way_idx_t victim_way
);

    // mid bit for the lower or upper half
    function automatic int unsigned mid_bit(input logic upper);
        return upper ? plru_hi_mid : plru_lo_mid;
    endfunction

    // leaf bit for a pair of ways
    function automatic int unsigned leaf_bit(input logic [1:0] pair);
        int unsigned idx;
        case (pair)
            2'b00:   idx = plru_leaf_01;
            2'b01:   idx = plru_leaf_23;
            2'b10:   idx = plru_leaf_45;
            default: idx = plru_leaf_67;
        endcase
        return idx;
    endfunction

    // walk away from the recorded direction at each level
    function automatic way_idx_t victim_of(input plru_t tree);
        way_idx_t v;
        v[2] = ~tree[plru_root];
        v[1] = ~tree[mid_bit(v[2])];
        v[0] = ~tree[leaf_bit(v[2:1])];
        return v;
    endfunction

    // only the three bits on the hit path change
    always_comb begin
        plru_next = plru;
        plru_next[plru_root] = hit_way[2];
        plru_next[mid_bit(hit_way[2])] = hit_way[1];
        plru_next[leaf_bit(hit_way[2:1])] = hit_way[0];
    end

    assign victim_way = victim_of(plru);

endmodule

// File: way_decode.sv
// hit vector to way index, lowest way wins if several are set
// victim dirty flag is taken from the external dirty array

`timescale 1ns/1ps

module way_decode import cache_geom_pkg::*; (
    input  way_vec_t hit,
    input  way_vec_t dirty,
    input  way_idx_t victim_way,
    output logic     hit_any,
    output way_idx_t hit_way,
    output logic     victim_dirty
);

    assign hit_any = |hit;

    // scan downward so the lowest set way is the last one written
    always_comb begin
        hit_way = '0;
        for (int i = num_ways - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_way = way_idx_t'(i);
            end
        end
    end

    assign victim_dirty = dirty[victim_way];

    // tag compare is expected to match at most one way
    always_comb begin
        if (!$isunknown(hit)) begin
            assert ($onehot0(hit))
                else $error("way_decode: multiple ways hit, vector %b", hit);
        end
    end

endmodule

// File: cache_ctrl_fsm.sv
// cache controller FSM, outputs are combinational from state and inputs
// cpu holds its request until done, memory request held until mem_resp

`timescale 1ns/1ps

module cache_ctrl_fsm import cache_geom_pkg::*, cache_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     read,
    input  logic     write,
    input  logic     mem_resp,
    input  logic     hit_any,
    input  way_idx_t hit_way,
    input  way_idx_t victim_way,
    input  logic     victim_dirty,
    output way_idx_t cacheline_sel,
    output way_vec_t fill_load,
    output way_vec_t dirty_load,
    output logic     dirty_in,
    output way_vec_t data_we,
    output logic     data_src_cpu,
    output logic     plru_load,
    output logic     pmem_read,
    output logic     pmem_write,
    output logic     new_address_sel,
    output logic     done
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    req_kind_t   req;

    always_comb begin
        if (read) begin
            req = req_read;
        end else if (write) begin
            req = req_write;
        end else begin
            req = req_none;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (req != req_none) begin
                    state_next = st_tag_check;
                end
            end
            st_tag_check: begin
                if (req == req_none || hit_any) begin
                    state_next = st_idle;
                end else if (victim_dirty) begin
                    state_next = st_miss_dirty;
                end else begin
                    state_next = st_miss_clean;
                end
            end
            st_miss_clean: begin
                if (mem_resp) begin
                    state_next = st_tag_check;
                end
            end
            st_miss_dirty: begin
                if (mem_resp) begin
                    state_next = st_miss_clean;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    // strobes per state
    always_comb begin
        cacheline_sel   = '0;
        fill_load       = '0;
        dirty_load      = '0;
        dirty_in        = 1'b0;
        data_we         = '0;
        data_src_cpu    = 1'b0;
        plru_load       = 1'b0;
        pmem_read       = 1'b0;
        pmem_write      = 1'b0;
        new_address_sel = 1'b0;
        done            = 1'b0;
        case (state)
            st_tag_check: begin
                if (req != req_none && hit_any) begin
                    cacheline_sel = hit_way;
                    plru_load     = 1'b1;
                    done          = 1'b1;
                    // write hit marks the line dirty and takes cpu data
                    if (req == req_write) begin
                        dirty_load[hit_way] = 1'b1;
                        dirty_in            = 1'b1;
                        data_we[hit_way]    = 1'b1;
                        data_src_cpu        = 1'b1;
                    end
                end
            end
            st_miss_clean: begin
                cacheline_sel         = victim_way;
                pmem_read             = 1'b1;
                fill_load[victim_way] = 1'b1;
                data_we[victim_way]   = 1'b1;
            end
            st_miss_dirty: begin
                // write back the victim and clear its dirty bit
                cacheline_sel          = victim_way;
                pmem_write             = 1'b1;
                new_address_sel        = 1'b1;
                dirty_load[victim_way] = 1'b1;
            end
            default: ;
        endcase
    end

    a_req_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(read && write))
        else $error("cache_ctrl_fsm: read and write both high");

    // a memory request stays up until memory answers
    a_mem_req_held: assert property (@(posedge clk) disable iff (rst)
        (pmem_read || pmem_write) && !mem_resp |=> $stable({pmem_read, pmem_write}))
        else $error("cache_ctrl_fsm: memory request dropped before mem_resp");

endmodule

// File: cache_ctrl.sv
// top of the 8-way cache controller, tag and data arrays live outside
// hit must be one-hot or zero while a request is in tag check

`timescale 1ns/1ps

module cache_ctrl import cache_geom_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     read,
    input  logic     write,
    input  way_vec_t hit,
    input  way_vec_t dirty,
    input  plru_t    plru,
    input  logic     mem_resp,
    output way_idx_t cacheline_sel,
    output way_vec_t fill_load,
    output way_vec_t dirty_load,
    output logic     dirty_in,
    output way_vec_t data_we,
    output logic     data_src_cpu,
    output logic     plru_load,
    output plru_t    plru_next,
    output logic     pmem_read,
    output logic     pmem_write,
    output logic     new_address_sel,
    output logic     done
);

    logic     hit_any;
    way_idx_t hit_way;
    way_idx_t victim_way;
    logic     victim_dirty;

    way_decode u_way_decode (
        .hit          (hit),
        .dirty        (dirty),
        .victim_way   (victim_way),
        .hit_any      (hit_any),
        .hit_way      (hit_way),
        .victim_dirty (victim_dirty)
    );

    plru_tree u_plru_tree (
        .plru       (plru),
        .hit_way    (hit_way),
        .plru_next  (plru_next),
        .victim_way (victim_way)
    );

    cache_ctrl_fsm u_cache_ctrl_fsm (
        .clk             (clk),
        .rst             (rst),
        .read            (read),
        .write           (write),
        .mem_resp        (mem_resp),
        .hit_any         (hit_any),
        .hit_way         (hit_way),
        .victim_way      (victim_way),
        .victim_dirty    (victim_dirty),
        .cacheline_sel   (cacheline_sel),
        .fill_load       (fill_load),
        .dirty_load      (dirty_load),
        .dirty_in        (dirty_in),
        .data_we         (data_we),
        .data_src_cpu    (data_src_cpu),
        .plru_load       (plru_load),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .new_address_sel (new_address_sel),
        .done            (done)
    );

endmodule

// File: tb_cache_ctrl.sv
// table-driven testbench for cache_ctrl, tag, dirty and memory sides are modeled here
// misses present no hit until the refill is over, then the victim way hits

`timescale 1ns/1ps

module tb_cache_ctrl import cache_geom_pkg::*, cache_ctrl_pkg::*; ();

    localparam int num_entries  = 16;
    localparam int max_delay    = 4;
    localparam int reset_cycles = 5;
    // a dirty miss walks two memory phases
    localparam int watchdog_cycles = num_entries * 2 * (4 + max_delay) + reset_cycles + 20;

    logic     clk;
    logic     rst;
    logic     read;
    logic     write;
    way_vec_t hit;
    way_vec_t dirty;
    plru_t    plru;
    logic     mem_resp;
    way_idx_t cacheline_sel;
    way_vec_t fill_load;
    way_vec_t dirty_load;
    logic     dirty_in;
    way_vec_t data_we;
    logic     data_src_cpu;
    logic     plru_load;
    plru_t    plru_next;
    logic     pmem_read;
    logic     pmem_write;
    logic     new_address_sel;
    logic     done;

    // stimulus and expected victim, one row per request
    req_kind_t tbl_kind   [num_entries];
    way_vec_t  tbl_hit    [num_entries];
    way_vec_t  tbl_dirty  [num_entries];
    plru_t     tbl_plru   [num_entries];
    int        tbl_delay  [num_entries];
    way_idx_t  tbl_victim [num_entries];

    int          errors;
    int          checks;
    logic [31:0] rng;

    cache_ctrl u_cache_ctrl (
        .clk             (clk),
        .rst             (rst),
        .read            (read),
        .write           (write),
        .hit             (hit),
        .dirty           (dirty),
        .plru            (plru),
        .mem_resp        (mem_resp),
        .cacheline_sel   (cacheline_sel),
        .fill_load       (fill_load),
        .dirty_load      (dirty_load),
        .dirty_in        (dirty_in),
        .data_we         (data_we),
        .data_src_cpu    (data_src_cpu),
        .plru_load       (plru_load),
        .plru_next       (plru_next),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .new_address_sel (new_address_sel),
        .done            (done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * 10);
        $display("watchdog expired, the controller stopped making progress");
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // node index of the tree: root 3, halves 1 and 5, pairs 0 2 4 6
    function automatic way_idx_t model_victim(input plru_t tree);
        int       node;
        int       step;
        way_idx_t v;
        node = 3;
        step = 2;
        for (int lvl = 2; lvl >= 0; lvl--) begin
            v[lvl] = ~tree[node];
            node = v[lvl] ? node + step : node - step;
            step = step / 2;
        end
        return v;
    endfunction

    function automatic plru_t model_update(input plru_t tree, input way_idx_t way);
        int    node;
        int    step;
        plru_t t;
        t = tree;
        node = 3;
        step = 2;
        for (int lvl = 2; lvl >= 0; lvl--) begin
            t[node] = way[lvl];
            node = way[lvl] ? node + step : node - step;
            step = step / 2;
        end
        return t;
    endfunction

    function automatic way_idx_t onehot_index(input way_vec_t v);
        way_idx_t idx;
        idx = '0;
        for (int i = 0; i < num_ways; i++) begin
            if (v[i]) begin
                idx = idx | way_idx_t'(i);
            end
        end
        return idx;
    endfunction

    function automatic string fmt_outputs(input way_idx_t s, input way_vec_t f, dl,
                                          input logic di, input way_vec_t we,
                                          input logic src, pl, rd, wr, nas, dn);
        return $sformatf(
            "sel=%0d fill=%h dld=%h din=%b we=%h src=%b pld=%b rd=%b wr=%b nas=%b done=%b",
            s, f, dl, di, we, src, pl, rd, wr, nas, dn);
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic check_outputs(input string what, input logic sel_care, input way_idx_t e_sel,
                                 input way_vec_t e_fill, e_dload, input logic e_din,
                                 input way_vec_t e_we, input logic e_src, e_pload,
                                 e_pread, e_pwrite, e_nas, e_done);
        way_idx_t sel_exp;
        checks++;
        // select is only meaningful while a way is being accessed
        sel_exp = sel_care ? e_sel : cacheline_sel;
        if ({cacheline_sel, fill_load, dirty_load, dirty_in, data_we, data_src_cpu, plru_load,
             pmem_read, pmem_write, new_address_sel, done} !==
            {sel_exp, e_fill, e_dload, e_din, e_we, e_src, e_pload, e_pread, e_pwrite, e_nas,
             e_done}) begin
            report_error($sformatf("%s: got %s", what,
                fmt_outputs(cacheline_sel, fill_load, dirty_load, dirty_in, data_we,
                            data_src_cpu, plru_load, pmem_read, pmem_write,
                            new_address_sel, done)));
            $display("    expected %s", fmt_outputs(sel_exp, e_fill, e_dload, e_din, e_we,
                                                    e_src, e_pload, e_pread, e_pwrite,
                                                    e_nas, e_done));
        end
    endtask

    task automatic check_quiet(input string what);
        check_outputs(what, 1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic set_entry(input int i, input req_kind_t k, input way_vec_t h, d,
                             input plru_t p, input int dl, input way_idx_t v);
        tbl_kind[i]   = k;
        tbl_hit[i]    = h;
        tbl_dirty[i]  = d;
        tbl_plru[i]   = p;
        tbl_delay[i]  = dl;
        tbl_victim[i] = v;
    endtask

    task automatic fill_table();
        rng = 32'h0a7ee0d5;
        // hits on fixed ways
        set_entry(0, req_read,  8'h01, 8'h00, 7'h00, 0, 3'd0);
        set_entry(1, req_read,  8'h20, 8'hff, 7'h2a, 0, 3'd0);
        set_entry(2, req_write, 8'h08, 8'h00, 7'h7f, 0, 3'd0);
        set_entry(3, req_write, 8'h80, 8'h00, 7'h33, 0, 3'd0);
        // misses with hand-walked victims
        set_entry(4, req_read,  8'h00, 8'h00, 7'h00, 1, 3'd7);
        set_entry(5, req_write, 8'h00, 8'h01, 7'h7f, 2, 3'd0);
        set_entry(6, req_read,  8'h00, 8'hff, 7'h08, 0, 3'd3);
        set_entry(7, req_write, 8'h00, 8'hbf, 7'h55, 3, 3'd6);
        for (int i = 8; i < num_entries; i++) begin
            rng = lcg_step(rng);
            if (i < 12) begin
                set_entry(i, (i % 2 == 0) ? req_read : req_write, 8'b1 << rng[30:28],
                          rng[23:16], rng[14:8], 0, 3'd0);
            end else begin
                set_entry(i, (i % 2 == 0) ? req_write : req_read, 8'h00, rng[23:16],
                          rng[14:8], int'(rng[27:25]) % (max_delay + 1),
                          model_victim(rng[14:8]));
            end
        end
    endtask

    // called right after the edge that enters the memory state
    task automatic memory_phase(input logic wb, input way_idx_t way, input int delay);
        way_vec_t wvec;
        wvec = 8'b1 << way;
        for (int c = 0; c <= delay; c++) begin
            mem_resp <= (c == delay);
            @(negedge clk);
            if (wb) begin
                check_outputs("write-back", 1'b1, way, '0, wvec, 1'b0, '0, 1'b0, 1'b0,
                              1'b0, 1'b1, 1'b1, 1'b0);
            end else begin
                check_outputs("refill", 1'b1, way, wvec, '0, 1'b0, wvec, 1'b0, 1'b0,
                              1'b1, 1'b0, 1'b0, 1'b0);
            end
            @(posedge clk);
        end
        mem_resp <= 1'b0;
    endtask

    task automatic run_entry(input int i);
        way_idx_t way;
        way_vec_t wvec;
        way_vec_t wr_vec;
        logic     is_wr;
        is_wr = (tbl_kind[i] == req_write);
        way = (tbl_hit[i] != '0) ? onehot_index(tbl_hit[i]) : tbl_victim[i];
        wvec = 8'b1 << way;
        wr_vec = is_wr ? wvec : way_vec_t'(0);
        @(posedge clk);
        read  <= (tbl_kind[i] == req_read);
        write <= is_wr;
        hit   <= tbl_hit[i];
        dirty <= tbl_dirty[i];
        plru  <= tbl_plru[i];
        @(negedge clk);
        check_quiet($sformatf("entry %0d idle with request", i));
        @(negedge clk);
        if (tbl_hit[i] == '0) begin
            check_quiet($sformatf("entry %0d tag check miss", i));
            @(posedge clk);
            if (tbl_dirty[i][way]) begin
                memory_phase(1'b1, way, tbl_delay[i]);
                dirty <= tbl_dirty[i] & ~wvec;
            end
            memory_phase(1'b0, way, tbl_delay[i]);
            // refilled line now matches in the tag array
            hit <= wvec;
            @(negedge clk);
        end
        check_outputs($sformatf("entry %0d done", i), 1'b1, way, '0, wr_vec, is_wr, wr_vec,
                      is_wr, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        checks++;
        if (plru_next !== model_update(tbl_plru[i], way)) begin
            report_error($sformatf("entry %0d plru_next %h expected %h", i, plru_next,
                                   model_update(tbl_plru[i], way)));
        end
        @(posedge clk);
        read  <= 1'b0;
        write <= 1'b0;
        hit   <= '0;
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        rst      = 1'b1;
        read     = 1'b0;
        write    = 1'b0;
        hit      = '0;
        dirty    = '0;
        plru     = '0;
        mem_resp = 1'b0;
        fill_table();
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_quiet("after reset");
        for (int i = 0; i < num_entries; i++) begin
            run_entry(i);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
cache_geom_pkg.sv
cache_ctrl_pkg.sv
plru_tree.sv
way_decode.sv
cache_ctrl_fsm.sv
cache_ctrl.sv
tb_cache_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run tb_cache_ctrl with Verilator, fail on build error or failing log

set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_cache_ctrl -Mdir obj_dir -o tb_cache_ctrl
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_cache_ctrl > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$log"; then
    exit 1
fi
if ! grep -q "RESULT: PASS" "$log"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
